// ==== common/periph_pkg.sv ====
// address map, widths and register encodings shared by the peripheral subsystem RTL
`default_nettype none

package periph_pkg;

   //*********************************************************************
   // bus and field widths
   //*********************************************************************

   // byte address from the outside bus
   localparam int WB_ADDR_W = 8;
   localparam int DATA_W    = 32;
   // register index taken from address bits 4..2
   localparam int REG_IDX_W = 3;

   localparam int LED_W    = 16;
   localparam int SWITCH_W = 16;
   localparam int BUTTON_W = 5;

   // kept short so the debouncer settles quickly in simulation
   localparam int DEBOUNCE_TICK_CYCLES = 8;

   //*********************************************************************
   // address map and register indices
   //*********************************************************************

   // selected by address bits 7..6, both upper codes are unmapped
   typedef enum logic [1:0] {
      REGION_GPIO     = 2'd0,
      REGION_TIMER    = 2'd1,
      REGION_UNMAPPED = 2'd2
   } periph_region_e;

   typedef enum logic [REG_IDX_W-1:0] {
      GPIO_LED      = 3'd0,
      GPIO_SWITCH   = 3'd1,
      GPIO_BUTTON   = 3'd2,
      GPIO_BTN_EDGE = 3'd3
   } gpio_reg_e;

   // ctrl bit 0 is count enable, bit 1 is interrupt enable
   typedef enum logic [REG_IDX_W-1:0] {
      TMR_CTRL    = 3'd0,
      TMR_COUNT   = 3'd1,
      TMR_COMPARE = 3'd2,
      TMR_STATUS  = 3'd3
   } timer_reg_e;

   typedef enum logic {
      BUS_IDLE = 1'b0,
      BUS_ACK  = 1'b1
   } bus_state_e;

endpackage

`default_nettype wire

// ==== common/periph_bus_if.sv ====
// register access channel from the bus decoder to one peripheral, one instance per region
`default_nettype none

interface periph_bus_if;

   // single cycle strobe for the addressed register
   logic                               stb;
   logic                               we;
   logic [periph_pkg::REG_IDX_W-1:0]   reg_idx;
   logic [periph_pkg::DATA_W-1:0]      wdat;
   // combinational readback of reg_idx
   logic [periph_pkg::DATA_W-1:0]      rdat;

   modport decoder (
      output stb,
      output we,
      output reg_idx,
      output wdat,
      input  rdat
   );

   modport peripheral (
      input  stb,
      input  we,
      input  reg_idx,
      input  wdat,
      output rdat
   );

endinterface

`default_nettype wire

// ==== gpio/input_debounce.sv ====
// sampled debouncer for the switch and button pins, used inside the GPIO register block
`default_nettype none

module input_debounce (
   input  wire  clk,
   input  wire  i_reset,
   input  wire  [periph_pkg::SWITCH_W+periph_pkg::BUTTON_W-1:0] i_raw,
   output logic [periph_pkg::SWITCH_W+periph_pkg::BUTTON_W-1:0] o_stable
);

   logic [periph_pkg::SWITCH_W+periph_pkg::BUTTON_W-1:0] sync1_q;
   logic [periph_pkg::SWITCH_W+periph_pkg::BUTTON_W-1:0] sync2_q;
   logic [periph_pkg::SWITCH_W+periph_pkg::BUTTON_W-1:0] sample_q;
   logic [periph_pkg::SWITCH_W+periph_pkg::BUTTON_W-1:0] agree;
   logic [$clog2(periph_pkg::DEBOUNCE_TICK_CYCLES)-1:0]  tick_cnt_q;
   logic                                                 tick;

   // two flop synchronizer for the asynchronous pins
   always_ff @(posedge clk) begin
      if (i_reset) begin
         sync1_q <= '0;
         sync2_q <= '0;
      end else begin
         sync1_q <= i_raw;
         sync2_q <= sync1_q;
      end
   end

   // sample tick every DEBOUNCE_TICK_CYCLES clocks
   assign tick = (tick_cnt_q ==
      ($clog2(periph_pkg::DEBOUNCE_TICK_CYCLES))'(periph_pkg::DEBOUNCE_TICK_CYCLES - 1));

   always_ff @(posedge clk) begin
      if (i_reset || tick) begin
         tick_cnt_q <= '0;
      end else begin
         tick_cnt_q <= tick_cnt_q + 1'b1;
      end
   end

   // bits where the new sample matches the previous one
   assign agree = ~(sync2_q ^ sample_q);

   always_ff @(posedge clk) begin
      if (i_reset) begin
         sample_q <= '0;
         o_stable <= '0;
      end else if (tick) begin
         sample_q <= sync2_q;
         o_stable <= (o_stable & ~agree) | (sync2_q & agree);
      end
   end

endmodule

`default_nettype wire

// ==== gpio/gpio_regs.sv ====
// GPIO register block with the LED register, debounced inputs and sticky button edge flags
`default_nettype none

module gpio_regs (
   input  wire                                 clk,
   input  wire                                 i_reset,
   input  wire  [periph_pkg::SWITCH_W-1:0]     i_switches,
   input  wire  [periph_pkg::BUTTON_W-1:0]     i_buttons,
   output logic [periph_pkg::LED_W-1:0]        o_led,
   periph_bus_if.peripheral                    bus
);

   logic [periph_pkg::SWITCH_W+periph_pkg::BUTTON_W-1:0] stable;
   logic [periph_pkg::SWITCH_W-1:0]                      switch_db;
   logic [periph_pkg::BUTTON_W-1:0]                      button_db;
   logic [periph_pkg::BUTTON_W-1:0]                      button_prev_q;
   logic [periph_pkg::BUTTON_W-1:0]                      btn_edge_q;
   logic [periph_pkg::BUTTON_W-1:0]                      btn_rise;
   logic [periph_pkg::BUTTON_W-1:0]                      btn_clear;
   logic                                                 wr;

   //*********************************************************************
   // input conditioning
   //*********************************************************************

   // buttons in the upper bits, switches in the lower
   input_debounce u_debounce (
      .clk      (clk),
      .i_reset  (i_reset),
      .i_raw    ({i_buttons, i_switches}),
      .o_stable (stable)
   );

   assign switch_db = stable[periph_pkg::SWITCH_W-1:0];
   assign button_db = stable[periph_pkg::SWITCH_W +: periph_pkg::BUTTON_W];

   //*********************************************************************
   // registers
   //*********************************************************************

   assign wr = bus.stb && bus.we;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_led <= '0;
      end else if (wr && (bus.reg_idx == periph_pkg::GPIO_LED)) begin
         o_led <= bus.wdat[periph_pkg::LED_W-1:0];
      end
   end

   // press detection on the debounced buttons
   assign btn_rise  = button_db & ~button_prev_q;
   assign btn_clear = (wr && (bus.reg_idx == periph_pkg::GPIO_BTN_EDGE)) ?
                      bus.wdat[periph_pkg::BUTTON_W-1:0] : '0;

   // a new press beats a clear in the same cycle
   always_ff @(posedge clk) begin
      if (i_reset) begin
         button_prev_q <= '0;
         btn_edge_q    <= '0;
      end else begin
         button_prev_q <= button_db;
         btn_edge_q    <= (btn_edge_q & ~btn_clear) | btn_rise;
      end
   end

   //*********************************************************************
   // readback, unused upper bits are zero
   //*********************************************************************

   always_comb begin
      bus.rdat = '0;
      case (bus.reg_idx)
         periph_pkg::GPIO_LED:      bus.rdat[periph_pkg::LED_W-1:0]    = o_led;
         periph_pkg::GPIO_SWITCH:   bus.rdat[periph_pkg::SWITCH_W-1:0] = switch_db;
         periph_pkg::GPIO_BUTTON:   bus.rdat[periph_pkg::BUTTON_W-1:0] = button_db;
         periph_pkg::GPIO_BTN_EDGE: bus.rdat[periph_pkg::BUTTON_W-1:0] = btn_edge_q;
         default:                   bus.rdat = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== timer/interval_timer.sv ====
// interval timer with free running count, compare match flag and interrupt output
`default_nettype none

module interval_timer (
   input  wire              clk,
   input  wire              i_reset,
   output logic             o_irq,
   periph_bus_if.peripheral bus
);

   logic                            cnt_en_q;
   logic                            irq_en_q;
   logic [periph_pkg::DATA_W-1:0]   count_q;
   logic [periph_pkg::DATA_W-1:0]   compare_q;
   logic                            match_q;
   logic                            match;
   logic                            wr;
   logic                            status_clear;

   assign wr = bus.stb && bus.we;

   // count reaching compare while enabled
   assign match = cnt_en_q && (count_q == compare_q);

   assign status_clear = wr && (bus.reg_idx == periph_pkg::TMR_STATUS) && bus.wdat[0];

   //*********************************************************************
   // control and compare registers
   //*********************************************************************

   always_ff @(posedge clk) begin
      if (i_reset) begin
         cnt_en_q  <= 1'b0;
         irq_en_q  <= 1'b0;
         compare_q <= '0;
      end else if (wr) begin
         if (bus.reg_idx == periph_pkg::TMR_CTRL) begin
            cnt_en_q <= bus.wdat[0];
            irq_en_q <= bus.wdat[1];
         end
         if (bus.reg_idx == periph_pkg::TMR_COMPARE) begin
            compare_q <= bus.wdat;
         end
      end
   end

   //*********************************************************************
   // counter and match flag
   //*********************************************************************

   // software load of the count wins over counting
   always_ff @(posedge clk) begin
      if (i_reset) begin
         count_q <= '0;
      end else if (wr && (bus.reg_idx == periph_pkg::TMR_COUNT)) begin
         count_q <= bus.wdat;
      end else if (match) begin
         count_q <= '0;
      end else if (cnt_en_q) begin
         count_q <= count_q + 1'b1;
      end
   end

   // a match in the same cycle as a clear keeps the flag set
   always_ff @(posedge clk) begin
      if (i_reset) begin
         match_q <= 1'b0;
      end else if (match) begin
         match_q <= 1'b1;
      end else if (status_clear) begin
         match_q <= 1'b0;
      end
   end

   assign o_irq = match_q && irq_en_q;

   // readback
   always_comb begin
      bus.rdat = '0;
      case (bus.reg_idx)
         periph_pkg::TMR_CTRL:    bus.rdat[1:0] = {irq_en_q, cnt_en_q};
         periph_pkg::TMR_COUNT:   bus.rdat = count_q;
         periph_pkg::TMR_COMPARE: bus.rdat = compare_q;
         periph_pkg::TMR_STATUS:  bus.rdat[0] = match_q;
         default:                 bus.rdat = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== src/bus_decoder.sv ====
// bus control for the subsystem, decodes each word access to a region and returns the ack
`default_nettype none

module bus_decoder (
   input  wire                                 clk,
   input  wire                                 i_reset,
   input  wire  [periph_pkg::WB_ADDR_W-1:0]    i_wb_adr,
   input  wire  [periph_pkg::DATA_W-1:0]       i_wb_dat,
   input  wire                                 i_wb_we,
   input  wire                                 i_wb_cyc,
   input  wire                                 i_wb_stb,
   output logic [periph_pkg::DATA_W-1:0]       o_wb_dat,
   output logic                                o_wb_ack,
   periph_bus_if.decoder                       gpio_bus,
   periph_bus_if.decoder                       timer_bus
);

   periph_pkg::bus_state_e          state_q;
   periph_pkg::periph_region_e      region;
   logic                            access;
   logic [periph_pkg::DATA_W-1:0]   rdat_sel;

   // new accesses are only taken from idle
   assign access = (state_q == periph_pkg::BUS_IDLE) && i_wb_cyc && i_wb_stb;

   //*********************************************************************
   // region decode from the top two address bits
   //*********************************************************************

   always_comb begin
      case (i_wb_adr[periph_pkg::WB_ADDR_W-1 -: 2])
         2'd0:    region = periph_pkg::REGION_GPIO;
         2'd1:    region = periph_pkg::REGION_TIMER;
         default: region = periph_pkg::REGION_UNMAPPED;
      endcase
   end

   // only the addressed peripheral sees a strobe
   assign gpio_bus.stb     = access && (region == periph_pkg::REGION_GPIO);
   assign gpio_bus.we      = i_wb_we;
   assign gpio_bus.reg_idx = i_wb_adr[periph_pkg::REG_IDX_W+1:2];
   assign gpio_bus.wdat    = i_wb_dat;

   assign timer_bus.stb     = access && (region == periph_pkg::REGION_TIMER);
   assign timer_bus.we      = i_wb_we;
   assign timer_bus.reg_idx = i_wb_adr[periph_pkg::REG_IDX_W+1:2];
   assign timer_bus.wdat    = i_wb_dat;

   // unmapped reads return zero
   always_comb begin
      case (region)
         periph_pkg::REGION_GPIO:  rdat_sel = gpio_bus.rdat;
         periph_pkg::REGION_TIMER: rdat_sel = timer_bus.rdat;
         default:                  rdat_sel = '0;
      endcase
   end

   //*********************************************************************
   // access FSM, one wait cycle then a single ack cycle
   //*********************************************************************

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state_q <= periph_pkg::BUS_IDLE;
      end else begin
         case (state_q)
            periph_pkg::BUS_IDLE: begin
               if (access) begin
                  state_q <= periph_pkg::BUS_ACK;
               end
            end
            default: begin
               state_q <= periph_pkg::BUS_IDLE;
            end
         endcase
      end
   end

   // read data captured on the same edge that raises ack
   always_ff @(posedge clk) begin
      if (access) begin
         o_wb_dat <= rdat_sel;
      end
   end

   assign o_wb_ack = (state_q == periph_pkg::BUS_ACK);

endmodule

`default_nettype wire

// ==== src/periph_subsystem.sv ====
// top level of the peripheral subsystem, connects the bus decoder to the GPIO block and timer
`default_nettype none

module periph_subsystem (
   input  wire                                 clk,
   input  wire                                 i_reset,

   // word bus from the outside master
   input  wire  [periph_pkg::WB_ADDR_W-1:0]    i_wb_adr,
   input  wire  [periph_pkg::DATA_W-1:0]       i_wb_dat,
   input  wire                                 i_wb_we,
   input  wire                                 i_wb_cyc,
   input  wire                                 i_wb_stb,
   output logic [periph_pkg::DATA_W-1:0]       o_wb_dat,
   output logic                                o_wb_ack,

   // board pins
   input  wire  [periph_pkg::SWITCH_W-1:0]     i_switches,
   input  wire  [periph_pkg::BUTTON_W-1:0]     i_buttons,
   output logic [periph_pkg::LED_W-1:0]        o_led,
   output logic                                o_timer_irq
);

   //*********************************************************************
   // per-region register channels
   //*********************************************************************

   periph_bus_if gpio_bus ();
   periph_bus_if timer_bus ();

   //*********************************************************************
   // bus control
   //*********************************************************************

   bus_decoder u_decoder (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_wb_adr   (i_wb_adr),
      .i_wb_dat   (i_wb_dat),
      .i_wb_we    (i_wb_we),
      .i_wb_cyc   (i_wb_cyc),
      .i_wb_stb   (i_wb_stb),
      .o_wb_dat   (o_wb_dat),
      .o_wb_ack   (o_wb_ack),
      .gpio_bus   (gpio_bus.decoder),
      .timer_bus  (timer_bus.decoder)
   );

   //*********************************************************************
   // peripherals
   //*********************************************************************

   gpio_regs u_gpio (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_switches (i_switches),
      .i_buttons  (i_buttons),
      .o_led      (o_led),
      .bus        (gpio_bus.peripheral)
   );

   interval_timer u_timer (
      .clk        (clk),
      .i_reset    (i_reset),
      .o_irq      (o_timer_irq),
      .bus        (timer_bus.peripheral)
   );

endmodule

`default_nettype wire

// ==== sim/periph_properties.sv ====
// bus and interrupt assertions that are bound into the subsystem top level in simulation
`default_nettype none

module periph_properties (
   input wire                                 clk,
   input wire                                 i_reset,
   input wire [periph_pkg::WB_ADDR_W-1:0]     i_wb_adr,
   input wire [periph_pkg::DATA_W-1:0]        i_wb_dat,
   input wire                                 i_wb_we,
   input wire                                 i_wb_cyc,
   input wire                                 i_wb_stb,
   input wire                                 i_wb_ack,
   input wire                                 i_timer_irq
);

   int   assert_fails = 0;
   logic ctrl_write;
   logic irq_en_model;

   // a request without ack in the same cycle is taken by the decoder
   assign ctrl_write = i_wb_cyc && i_wb_stb && !i_wb_ack && i_wb_we &&
                       (i_wb_adr[periph_pkg::WB_ADDR_W-1 -: 2] == periph_pkg::REGION_TIMER) &&
                       (i_wb_adr[periph_pkg::REG_IDX_W+1:2] == periph_pkg::TMR_CTRL);

   // interrupt enable as last written to the timer control register
   always_ff @(posedge clk) begin
      if (i_reset) begin
         irq_en_model <= 1'b0;
      end else if (ctrl_write) begin
         irq_en_model <= i_wb_dat[1];
      end
   end

   // ack lasts a single cycle
   ack_single_cycle: assert property (@(posedge clk) disable iff (i_reset)
      i_wb_ack |=> !i_wb_ack)
      else begin
         $error("ack held high for two cycles");
         assert_fails++;
      end

   // ack only answers a request seen one cycle earlier
   ack_follows_request: assert property (@(posedge clk) disable iff (i_reset)
      i_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
      else begin
         $error("ack without a request in the previous cycle");
         assert_fails++;
      end

   irq_masked: assert property (@(posedge clk) disable iff (i_reset)
      !irq_en_model |-> !i_timer_irq)
      else begin
         $error("timer interrupt high while interrupt enable is clear");
         assert_fails++;
      end

   // outputs quiet right after a reset cycle
   quiet_after_reset: assert property (@(posedge clk)
      i_reset |=> (!i_wb_ack && !i_timer_irq))
      else begin
         $error("ack or timer interrupt high after reset");
         assert_fails++;
      end

endmodule

bind periph_subsystem periph_properties u_properties (
   .clk         (clk),
   .i_reset     (i_reset),
   .i_wb_adr    (i_wb_adr),
   .i_wb_dat    (i_wb_dat),
   .i_wb_we     (i_wb_we),
   .i_wb_cyc    (i_wb_cyc),
   .i_wb_stb    (i_wb_stb),
   .i_wb_ack    (o_wb_ack),
   .i_timer_irq (o_timer_irq)
);

`default_nettype wire

// ==== sim/tb_periph_subsystem.sv ====
// testbench for the peripheral subsystem that runs the bus operations listed in the test data file
`default_nettype none

module tb_periph_subsystem;

   localparam int CLK_HALF     = 20;
   localparam int RESET_CYCLES = 10;
   localparam int ACK_TIMEOUT  = 16;
   localparam int POLL_LIMIT   = 200;

   logic                               clk;
   logic                               reset;
   logic [periph_pkg::WB_ADDR_W-1:0]   wb_adr;
   logic [periph_pkg::DATA_W-1:0]      wb_dat_w;
   logic                               wb_we;
   logic                               wb_cyc;
   logic                               wb_stb;
   logic [periph_pkg::DATA_W-1:0]      wb_dat_r;
   logic                               wb_ack;
   logic [periph_pkg::SWITCH_W-1:0]    switches;
   logic [periph_pkg::BUTTON_W-1:0]    buttons;
   logic [periph_pkg::LED_W-1:0]       led;
   logic                               timer_irq;

   int          fd;
   int          n_fields;
   int          pass_count;
   int          fail_count;
   string       line;
   string       test_name;
   string       op;
   logic [31:0] f_adr;
   logic [31:0] f_dat;
   logic [31:0] f_exp;
   logic        test_ok;

   periph_subsystem uut (
      .clk         (clk),
      .i_reset     (reset),
      .i_wb_adr    (wb_adr),
      .i_wb_dat    (wb_dat_w),
      .i_wb_we     (wb_we),
      .i_wb_cyc    (wb_cyc),
      .i_wb_stb    (wb_stb),
      .o_wb_dat    (wb_dat_r),
      .o_wb_ack    (wb_ack),
      .i_switches  (switches),
      .i_buttons   (buttons),
      .o_led       (led),
      .o_timer_irq (timer_irq)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #CLK_HALF clk = ~clk;
      end
   end

   //**********************************************************************
   // bus master
   //**********************************************************************

   // one word access with outputs sampled on the falling edge
   task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                             output logic [31:0] rd, output logic got_ack);
      int waited;
      waited  = 0;
      got_ack = 1'b0;
      @(posedge clk);
      wb_adr   <= adr[periph_pkg::WB_ADDR_W-1:0];
      wb_dat_w <= dat;
      wb_we    <= we;
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      while (!got_ack && waited < ACK_TIMEOUT) begin
         @(negedge clk);
         got_ack = wb_ack;
         waited++;
      end
      rd = wb_dat_r;
      // drop the request in the ack cycle so no second access starts
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   //**********************************************************************
   // one line of test data
   //**********************************************************************

   task automatic run_test(input string name, input string code, input logic [31:0] adr,
                           input logic [31:0] dat, input logic [31:0] exp, output logic ok);
      logic [31:0] rd;
      logic        got_ack;
      int          polls;
      ok      = 1'b1;
      rd      = '0;
      got_ack = 1'b1;
      polls   = 0;
      if (code == "W" || code == "R") begin
         bus_access(code == "W", adr, dat, rd, got_ack);
         if (!got_ack) begin
            $display("no ack from bus at address %h in test %s", adr[7:0], name);
            ok = 1'b0;
         end else if (code == "R" && rd !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, rd);
            ok = 1'b0;
         end
      end else if (code == "S") begin
         @(posedge clk);
         switches <= dat[periph_pkg::SWITCH_W-1:0];
      end else if (code == "B") begin
         @(posedge clk);
         buttons <= dat[periph_pkg::BUTTON_W-1:0];
      end else if (code == "P") begin
         rd = ~exp;
         while (got_ack && rd !== exp && polls < POLL_LIMIT) begin
            bus_access(1'b0, adr, '0, rd, got_ack);
            polls++;
         end
         if (!got_ack) begin
            $display("no ack from bus while polling %h in test %s", adr[7:0], name);
            ok = 1'b0;
         end else if (rd !== exp) begin
            $display("register %h never reached %h in %0d reads in test %s, last read %h",
                     adr[7:0], exp, POLL_LIMIT, name, rd);
            ok = 1'b0;
         end
      end else if (code == "L") begin
         @(negedge clk);
         if (led !== exp[periph_pkg::LED_W-1:0]) begin
            $display("MISMATCH %s expected %h actual %h", name,
                     exp[periph_pkg::LED_W-1:0], led);
            ok = 1'b0;
         end
      end else if (code == "I") begin
         @(negedge clk);
         if (timer_irq !== exp[0]) begin
            $display("MISMATCH %s expected %b actual %b", name, exp[0], timer_irq);
            ok = 1'b0;
         end
      end else begin
         $display("unknown operation %s in test %s", code, name);
         ok = 1'b0;
      end
   endtask

   //**********************************************************************
   // main sequence
   //**********************************************************************

   initial begin
      reset      = 1'b1;
      wb_adr     = '0;
      wb_dat_w   = '0;
      wb_we      = 1'b0;
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      switches   = '0;
      buttons    = '0;
      pass_count = 0;
      fail_count = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;

      fd = $fopen("sim/periph_testdata.txt", "r");
      if (fd == 0) begin
         $display("could not open the test data file");
         fail_count++;
      end else begin
         while (!$feof(fd)) begin
            line     = "";
            n_fields = $fgets(line, fd);
            // skip comments and empty lines
            if (n_fields > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
               n_fields = $sscanf(line, "%s %s %h %h %h", test_name, op, f_adr, f_dat, f_exp);
               if (n_fields != 5) begin
                  $display("malformed line in test data file: %s", line);
                  fail_count++;
               end else begin
                  run_test(test_name, op, f_adr, f_dat, f_exp, test_ok);
                  if (test_ok) begin
                     $display("PASS %s", test_name);
                     pass_count++;
                  end else begin
                     $display("FAIL %s", test_name);
                     fail_count++;
                  end
               end
            end
         end
         $fclose(fd);
         if (pass_count == 0) begin
            $display("no tests were found in the test data file");
            fail_count++;
         end
      end

      if (uut.u_properties.assert_fails != 0) begin
         $display("%0d assertion failures during the run", uut.u_properties.assert_fails);
         fail_count += uut.u_properties.assert_fails;
      end

      $display("tests passed: %0d  failed: %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim/periph_testdata.txt ====
# columns: test name, operation (W R S B P L I), address, data, expected value
# address, data and expected value are hex, fields an operation ignores are 0
led_reset_read     R 00 00000000 00000000
led_reset_pin      L 00 00000000 00000000
led_write          W 00 abcd1234 00000000
led_read           R 00 00000000 00001234
led_pin            L 00 00000000 00001234
sw_set             S 00 0000a5c3 00000000
btn_set            B 00 0000000a 00000000
sw_poll            P 04 00000000 0000a5c3
btn_poll           P 08 00000000 0000000a
btn_release        B 00 00000000 00000000
btn_release_poll   P 08 00000000 00000000
edge_clear_all     W 0c 0000001f 00000000
edge_empty         R 0c 00000000 00000000
btn_press          B 00 00000015 00000000
btn_press_poll     P 08 00000000 00000015
edge_read          R 0c 00000000 00000015
edge_clear_some    W 0c 00000005 00000000
edge_after_clear   R 0c 00000000 00000010
btn_off            B 00 00000000 00000000
btn_off_poll       P 08 00000000 00000000
edge_after_off     R 0c 00000000 00000010
tmr_compare        W 48 00000004 00000000
tmr_enable_both    W 40 00000003 00000000
tmr_match_poll     P 4c 00000000 00000001
tmr_irq_high       I 00 00000000 00000001
tmr_stop_count     W 40 00000002 00000000
tmr_clear_flag     W 4c 00000001 00000000
tmr_flag_cleared   R 4c 00000000 00000000
tmr_irq_low        I 00 00000000 00000000
tmr_count_zero     W 44 00000000 00000000
tmr_enable_count   W 40 00000001 00000000
tmr_match_no_irq   P 4c 00000000 00000001
tmr_irq_masked     I 00 00000000 00000000
tmr_disable        W 40 00000000 00000000
tmr_clear_again    W 4c 00000001 00000000
unmap_write_r2     W 80 deadbeef 00000000
unmap_read_r2      R 80 00000000 00000000
unmap_write_r3     W cc ffffffff 00000000
unmap_read_r3      R cc 00000000 00000000
keep_led           R 00 00000000 00001234
keep_led_pin       L 00 00000000 00001234
keep_switch        R 04 00000000 0000a5c3
keep_edge          R 0c 00000000 00000010
keep_ctrl          R 40 00000000 00000000
keep_compare       R 48 00000000 00000004
keep_status        R 4c 00000000 00000000

// ==== tb.f ====
common/periph_pkg.sv
common/periph_bus_if.sv
gpio/input_debounce.sv
gpio/gpio_regs.sv
timer/interval_timer.sv
src/bus_decoder.sv
src/periph_subsystem.sv
sim/periph_properties.sv
sim/tb_periph_subsystem.sv
